// File: tb.f
+incdir+.
maze_pkg.sv
link_pkg.sv
map_loader.sv
wave_grid.sv
path_tracer.sv
route_ctrl.sv
maze_router.sv
tb_maze_router.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the maze router testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_maze_router -f tb.f -o tb_sim &&
out="$(./obj_dir/tb_sim)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "all tests passed" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb_cases.svh
/*
 * maze router test cases on an 8 by 8 grid
 * expected cost is the shortest path length minus one
 */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// byte r of rows is map row r, bit x set blocks column x
typedef struct packed {
	logic [7:0][7:0] rows;
	logic [2:0]      src_x;
	logic [2:0]      src_y;
	logic [2:0]      snk_x;
	logic [2:0]      snk_y;
	logic            routable;
	logic [9:0]      cost;
} maze_case_t;

localparam int num_cases = 8;

// columns: rows, source x, source y, sink x, sink y, routable, cost
localparam maze_case_t maze_cases [num_cases] = '{
	'{64'h0000000000000000, 3'd0, 3'd0, 3'd7, 3'd7, 1'b1, 10'd13},
	'{64'h0000000000000000, 3'd3, 3'd3, 3'd4, 3'd3, 1'b1, 10'd0},
	'{64'h0000000000000000, 3'd6, 3'd1, 3'd2, 3'd5, 1'b1, 10'd7},
	'{64'h0010101010101010, 3'd1, 3'd1, 3'd6, 3'd1, 1'b1, 10'd16},  // wall on column 4
	'{64'h000000FE00000000, 3'd7, 3'd0, 3'd7, 3'd7, 1'b1, 10'd20},  // gap at column 0
	'{64'h0020502000000000, 3'd0, 3'd0, 3'd5, 3'd5, 1'b0, 10'd0},   // sink boxed in
	'{64'h0000000000000102, 3'd0, 3'd0, 3'd3, 3'd3, 1'b0, 10'd0},   // source boxed in
	'{64'h00002424243C0000, 3'd3, 3'd3, 3'd3, 3'd0, 1'b1, 10'd12}   // cup open below
};

`endif

// File: tb_maze_router.sv
/*
 * testbench of the maze router
 * loads the case table, checks each result and the credit back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tb_maze_router;
	import maze_pkg::*;
	import link_pkg::*;

	`include "tb_cases.svh"

	localparam int clk_period  = 8;
	localparam int num_runs    = num_cases + 3;
	localparam int result_wait = 300;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	in_word_t in_word;
	logic     busy;
	logic     res_valid;
	result_t  res;
	logic     res_credit;

	integer seed;
	int     errors;
	int     checks;
	int     owed;
	logic   credit_en;

	maze_router #(
		.GRID_DIM      (8),
		.RESULT_CREDITS(2)
	) i_maze_router (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_word   (in_word),
		.busy      (busy),
		.res_valid (res_valid),
		.res       (res),
		.res_credit(res_credit)
	);

	always #(clk_period / 2) clk = ~clk;

	// -------------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------------
	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic wait_idle();
		while (busy) begin
			@(negedge clk);
		end
	endtask

	task automatic send_case(input int idx);
		maze_case_t c;
		c = maze_cases[idx];
		for (int r = 0; r < 8; r++) begin
			check_value("res_valid", res_valid, 0);
			in_valid            = 1'b1;
			in_word             = '0;
			in_word.kind        = kind_row;
			in_word.payload.row = row_bits_t'(c.rows[r]);
			@(negedge clk);
		end
		in_word                           = '0;
		in_word.kind                      = kind_terms;
		in_word.payload.term.terms.source = '{x: coord_t'(c.src_x), y: coord_t'(c.src_y)};
		in_word.payload.term.terms.sink   = '{x: coord_t'(c.snk_x), y: coord_t'(c.snk_y)};
		@(negedge clk);
		in_valid = 1'b0;
		in_word  = '0;
		check_value("busy", busy, 1);
	endtask

	task automatic wait_result(input int idx);
		maze_case_t c;
		int         n;
		c = maze_cases[idx];
		n = 0;
		while (!res_valid && n < result_wait) begin
			@(negedge clk);
			n++;
		end
		if (!res_valid) begin
			errors++;
			$display("no result for case %0d within %0d cycles", idx, result_wait);
		end else begin
			check_value("res.routable", res.routable, c.routable);
			check_value("res.cost", res.cost, c.cost);
			@(negedge clk);
			// result is a single cycle pulse
			check_value("res_valid", res_valid, 0);
		end
	endtask

	task automatic run_case(input int idx);
		wait_idle();
		send_case(idx);
		wait_result(idx);
	endtask

	// -------------------------------------------------------------------------
	// consumer that hands back one credit per result at random moments
	// -------------------------------------------------------------------------
	initial begin
		res_credit = 1'b0;
		owed       = 0;
		forever begin
			@(negedge clk);
			res_credit = 1'b0;
			if (res_valid)
				owed++;
			if (credit_en && owed > 0 && ($random(seed) & 3) == 0) begin
				res_credit = 1'b1;
				owed--;
			end
		end
	end

	// -------------------------------------------------------------------------
	// main sequence
	// -------------------------------------------------------------------------
	initial begin
		seed      = 32'h7098;
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_word   = '0;
		credit_en = 1'b1;
		errors    = 0;
		checks    = 0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		check_value("busy", busy, 0);
		check_value("res_valid", res_valid, 0);

		for (int i = 0; i < num_cases; i++)
			run_case(i);

		// back to the full credit count before two routes with no credit returned
		while (owed != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
		credit_en = 1'b0;
		run_case(1);
		run_case(2);

		// third result must wait in the report state
		wait_idle();
		send_case(3);
		repeat (100) begin
			@(negedge clk);
			check_value("res_valid", res_valid, 0);
			check_value("busy", busy, 1);
		end
		credit_en = 1'b1;
		wait_result(3);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// hard stop sized by the number of routes
	initial begin
		#(num_runs * 300 * clk_period);
		$display("watchdog expired before the last route finished");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: maze_router.sv
/*
 * single-net Lee maze router
 * host loads the obstacle map and terminals, the result leaves on a credit channel
 */
`timescale 1ns/1ps
`default_nettype none

module maze_router #(
	parameter int GRID_DIM       = 16,
	parameter int RESULT_CREDITS = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  link_pkg::in_word_t in_word,
	output logic               busy,
	output logic               res_valid,
	output link_pkg::result_t  res,
	input  logic               res_credit
);
	import maze_pkg::*;
	import link_pkg::*;

	logic       row_we;
	coord_t     row_idx;
	row_bits_t  row_data;
	terminals_t terms;
	logic       load_done;
	logic       seed;
	logic       expand;
	logic       trace;
	point_t     probe;
	nbr_t       nbr;
	logic [1:0] phase;
	logic       sink_reached;
	logic       stalled;
	logic       at_source;
	logic [9:0] cost;

	route_ctrl #(
		.RESULT_CREDITS(RESULT_CREDITS)
	) i_route_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_done   (load_done),
		.sink_reached(sink_reached),
		.stalled     (stalled),
		.at_source   (at_source),
		.res_credit  (res_credit),
		.cost        (cost),
		.seed        (seed),
		.expand      (expand),
		.trace       (trace),
		.busy        (busy),
		.res_valid   (res_valid),
		.res         (res)
	);

	map_loader #(
		.GRID_DIM(GRID_DIM)
	) i_map_loader (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_word  (in_word),
		.row_we   (row_we),
		.row_idx  (row_idx),
		.row_data (row_data),
		.terms    (terms),
		.load_done(load_done)
	);

	wave_grid #(
		.GRID_DIM(GRID_DIM)
	) i_wave_grid (
		.clk         (clk),
		.rst_n       (rst_n),
		.row_we      (row_we),
		.row_idx     (row_idx),
		.row_data    (row_data),
		.terms       (terms),
		.seed        (seed),
		.expand      (expand),
		.probe       (probe),
		.nbr         (nbr),
		.phase       (phase),
		.sink_reached(sink_reached),
		.stalled     (stalled)
	);

	path_tracer i_path_tracer (
		.clk      (clk),
		.rst_n    (rst_n),
		.terms    (terms),
		.trace    (trace),
		.phase    (phase),
		.nbr      (nbr),
		.probe    (probe),
		.at_source(at_source),
		.cost     (cost)
	);

endmodule

`default_nettype wire

// File: route_ctrl.sv
/*
 * routing sequencer
 * idle, seed, expand, trace, report, plus the result credit counter
 */
`timescale 1ns/1ps
`default_nettype none

module route_ctrl #(
	parameter int RESULT_CREDITS = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load_done,
	input  logic              sink_reached,
	input  logic              stalled,
	input  logic              at_source,
	input  logic              res_credit,
	input  logic [9:0]        cost,
	output logic              seed,
	output logic              expand,
	output logic              trace,
	output logic              busy,
	output logic              res_valid,
	output link_pkg::result_t res
);
	localparam int cred_w = $clog2(RESULT_CREDITS + 1);
	localparam logic [cred_w-1:0] cred_max = cred_w'(RESULT_CREDITS);

	typedef enum logic [2:0] {
		st_idle,
		st_seed,
		st_expand,
		st_trace,
		st_report
	} state_t;

	state_t            state;
	logic [cred_w-1:0] credits;

	// -------------------------------------------------------------------------
	// state machine
	// -------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			res   <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (load_done)
						state <= st_seed;
				end
				st_seed: state <= st_expand;
				st_expand: begin
					if (sink_reached) begin
						state <= st_trace;
					end else if (stalled) begin
						// wave died out before touching the sink
						res.routable <= 1'b0;
						res.cost     <= '0;
						state        <= st_report;
					end
				end
				st_trace: begin
					if (at_source) begin
						res.routable <= 1'b1;
						res.cost     <= cost;
						state        <= st_report;
					end
				end
				st_report: begin
					if (res_valid)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign seed      = (state == st_seed);
	assign expand    = (state == st_expand) && !sink_reached && !stalled;
	assign trace     = (state == st_trace) && !at_source;
	assign busy      = load_done || (state != st_idle);
	assign res_valid = (state == st_report) && (credits != '0);

	// -------------------------------------------------------------------------
	// result credits, one spent per result, one back per res_credit
	// -------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			credits <= cred_max;
		else if (res_valid && !res_credit)
			credits <= credits - 1'b1;
		else if (res_credit && !res_valid && (credits != cred_max))
			credits <= credits + 1'b1;
	end

endmodule

`default_nettype wire

// File: path_tracer.sv
/*
 * backtrace from sink to source
 * follows the wave codes downhill one cell per cycle and counts the cells
 */
`timescale 1ns/1ps
`default_nettype none

module path_tracer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  link_pkg::terminals_t terms,
	input  logic                 trace,
	input  logic [1:0]           phase,
	input  maze_pkg::nbr_t       nbr,
	output maze_pkg::point_t     probe,
	output logic                 at_source,
	output logic [9:0]           cost
);
	import maze_pkg::*;

	point_t     pt;
	point_t     nxt;
	logic [1:0] tphase;
	logic [1:0] want_phase;
	cell_t      want;

	// code one ring closer to the source
	assign want_phase = tphase - 2'd1;
	assign want       = want_phase[1] ? wave_b : wave_a;

	// fixed preference down, up, right, left
	always_comb begin
		nxt = pt;
		if (nbr.down_ok && (nbr.down == want))
			nxt.y = pt.y + 1'b1;
		else if (nbr.up_ok && (nbr.up == want))
			nxt.y = pt.y - 1'b1;
		else if (nbr.right_ok && (nbr.right == want))
			nxt.x = pt.x + 1'b1;
		else if (nbr.left_ok && (nbr.left == want))
			nxt.x = pt.x - 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pt     <= '0;
			tphase <= '0;
			cost   <= '0;
		end else if (!trace) begin
			// park on the sink with the phase of the last ring
			pt     <= terms.sink;
			tphase <= phase - 2'd1;
			cost   <= '0;
		end else begin
			pt     <= nxt;
			tphase <= want_phase;
			if (nxt != terms.source)
				cost <= cost + 10'd1;
		end
	end

	assign probe     = pt;
	assign at_source = (pt == terms.source);

endmodule

`default_nettype wire

// File: wave_grid.sv
/*
 * cell array of the router
 * loads obstacles, seeds the source, grows the wavefront one ring per cycle
 * and serves the four neighbours of the tracer point
 */
`timescale 1ns/1ps
`default_nettype none

module wave_grid #(
	parameter int GRID_DIM = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 row_we,
	input  maze_pkg::coord_t     row_idx,
	input  maze_pkg::row_bits_t  row_data,
	input  link_pkg::terminals_t terms,
	input  logic                 seed,
	input  logic                 expand,
	input  maze_pkg::point_t     probe,
	output maze_pkg::nbr_t       nbr,
	output logic [1:0]           phase,
	output logic                 sink_reached,
	output logic                 stalled
);
	import maze_pkg::*;

	localparam int idx_w = $clog2(GRID_DIM);

	cell_t               grid [GRID_DIM][GRID_DIM];
	logic [GRID_DIM+1:0] wave_pad [GRID_DIM+2];
	logic [GRID_DIM-1:0] grow [GRID_DIM];
	logic                any_grow;
	cell_t               step_code;
	logic [idx_w-1:0]    ri;
	logic [idx_w-1:0]    src_x, src_y, snk_x, snk_y;
	logic [idx_w-1:0]    pr_x, pr_y, up_y, dn_y, lf_x, rt_x;

	assign ri    = row_idx[idx_w-1:0];
	assign src_x = terms.source.x[idx_w-1:0];
	assign src_y = terms.source.y[idx_w-1:0];
	assign snk_x = terms.sink.x[idx_w-1:0];
	assign snk_y = terms.sink.y[idx_w-1:0];

	// phase 0,1 paint wave_a and phase 2,3 paint wave_b
	assign step_code = phase[1] ? wave_b : wave_a;

	// -------------------------------------------------------------------------
	// wavefront growth, wave bits padded with a zero border
	// -------------------------------------------------------------------------
	always_comb begin
		for (int y = 0; y < GRID_DIM + 2; y++)
			wave_pad[y] = '0;
		for (int y = 0; y < GRID_DIM; y++) begin
			for (int x = 0; x < GRID_DIM; x++)
				wave_pad[y + 1][x + 1] = grid[y][x][1];
		end
	end

	always_comb begin
		any_grow = 1'b0;
		for (int y = 0; y < GRID_DIM; y++) begin
			for (int x = 0; x < GRID_DIM; x++) begin
				grow[y][x] = (grid[y][x] == cell_free) &&
					(wave_pad[y][x + 1] || wave_pad[y + 2][x + 1] ||
					 wave_pad[y + 1][x] || wave_pad[y + 1][x + 2]);
				any_grow = any_grow || grow[y][x];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int y = 0; y < GRID_DIM; y++) begin
				for (int x = 0; x < GRID_DIM; x++)
					grid[y][x] <= cell_free;
			end
		end else if (row_we) begin
			for (int x = 0; x < GRID_DIM; x++)
				grid[ri][x] <= row_data[x] ? cell_block : cell_free;
		end else if (seed) begin
			// source written last so it wins if both coincide
			grid[snk_y][snk_x] <= cell_free;
			grid[src_y][src_x] <= wave_b;
		end else if (expand) begin
			for (int y = 0; y < GRID_DIM; y++) begin
				for (int x = 0; x < GRID_DIM; x++) begin
					if (grow[y][x])
						grid[y][x] <= step_code;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase   <= '0;
			stalled <= 1'b0;
		end else if (seed) begin
			phase   <= '0;
			stalled <= 1'b0;
		end else if (expand) begin
			phase   <= phase + 2'd1;
			stalled <= !any_grow;
		end
	end

	assign sink_reached = (grid[snk_y][snk_x] != cell_free);

	// -------------------------------------------------------------------------
	// neighbour reads for the tracer
	// -------------------------------------------------------------------------
	assign pr_x = probe.x[idx_w-1:0];
	assign pr_y = probe.y[idx_w-1:0];
	assign up_y = pr_y - 1'b1;
	assign dn_y = pr_y + 1'b1;
	assign lf_x = pr_x - 1'b1;
	assign rt_x = pr_x + 1'b1;

	always_comb begin
		nbr.up_ok    = (probe.y != '0);
		nbr.up       = grid[up_y][pr_x];
		nbr.down_ok  = (probe.y != coord_t'(GRID_DIM - 1));
		nbr.down     = grid[dn_y][pr_x];
		nbr.left_ok  = (probe.x != '0);
		nbr.left     = grid[pr_y][lf_x];
		nbr.right_ok = (probe.x != coord_t'(GRID_DIM - 1));
		nbr.right    = grid[pr_y][rt_x];
	end

endmodule

`default_nettype wire

// File: map_loader.sv
/*
 * host word decoder
 * turns row words into grid row writes and latches the terminal pair
 */
`timescale 1ns/1ps
`default_nettype none

module map_loader #(
	parameter int GRID_DIM = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  link_pkg::in_word_t   in_word,
	output logic                 row_we,
	output maze_pkg::coord_t     row_idx,
	output maze_pkg::row_bits_t  row_data,
	output link_pkg::terminals_t terms,
	output logic                 load_done
);
	import maze_pkg::*;
	import link_pkg::*;

	// columns beyond the grid side are dropped
	localparam row_bits_t row_mask = row_bits_t'((64'd1 << GRID_DIM) - 64'd1);

	coord_t row_cnt;
	logic   is_row;
	logic   is_terms;

	assign is_row   = in_valid && (in_word.kind == kind_row);
	assign is_terms = in_valid && (in_word.kind == kind_terms);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_cnt   <= '0;
			row_we    <= 1'b0;
			load_done <= 1'b0;
			terms     <= '0;
		end else begin
			row_we    <= is_row;
			load_done <= is_terms;
			if (is_row) begin
				row_cnt <= row_cnt + 1'b1;
			end else if (is_terms) begin
				// next frame starts again at row 0
				row_cnt <= '0;
				terms   <= in_word.payload.term.terms;
			end
		end
	end

	// row write goes out one cycle after acceptance
	always_ff @(posedge clk) begin
		if (is_row) begin
			row_idx  <= row_cnt;
			row_data <= in_word.payload.row & row_mask;
		end
	end

endmodule

`default_nettype wire

// File: link_pkg.sv
/*
 * host and result words at the router boundary
 * one input word carries either a map row or the terminal pair
 */
`default_nettype none

package link_pkg;

	// kind bit of an input word
	localparam logic kind_row   = 1'b0;
	localparam logic kind_terms = 1'b1;

	typedef struct packed {
		maze_pkg::point_t source;
		maze_pkg::point_t sink;
	} terminals_t;

	// terminal pair padded up to a full row word
	typedef struct packed {
		logic [maze_pkg::MAX_DIM-$bits(terminals_t)-1:0] pad;
		terminals_t                                       terms;
	} term_word_t;

	typedef union packed {
		maze_pkg::row_bits_t row;
		term_word_t          term;
	} in_payload_u;

	typedef struct packed {
		logic        kind;
		in_payload_u payload;
	} in_word_t;

	// routable low always comes with cost zero
	typedef struct packed {
		logic       routable;
		logic [9:0] cost;
	} result_t;

endpackage

`default_nettype wire

// File: maze_pkg.sv
/*
 * maze router geometry and cell codes
 * shared by the grid, the row loader and the path tracer
 */
`default_nettype none

package maze_pkg;

	// -------------------------------------------------------------------------
	// grid geometry
	// -------------------------------------------------------------------------
	localparam int MAX_DIM = 32;

	typedef logic [4:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	// one obstacle bit per column, bit x is column x
	typedef logic [MAX_DIM-1:0] row_bits_t;

	// -------------------------------------------------------------------------
	// cell codes, the wave runs 2 2 3 3 2 2 ... outward from the source
	// -------------------------------------------------------------------------
	typedef enum logic [1:0] {
		cell_free  = 2'd0,
		cell_block = 2'd1,
		wave_a     = 2'd2,
		wave_b     = 2'd3
	} cell_t;

	// the four cells around a probe point, ok low when off the grid
	typedef struct packed {
		logic  up_ok;
		cell_t up;
		logic  down_ok;
		cell_t down;
		logic  left_ok;
		cell_t left;
		logic  right_ok;
		cell_t right;
	} nbr_t;

endpackage

`default_nettype wire
